// ==== include/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Frame payload width
`define UART_DATA_BITS 8

// Entries held by each FIFO
`define UART_FIFO_DEPTH 8

// Baud divisor register
`define UART_DIV_WIDTH 16
`define UART_DEFAULT_DIV 16'd26

`endif

// ==== logic/uart_pkg.sv ====
`include "uart_cfg.svh"

package uart_pkg;

  typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

  // Receive FIFO entry, error flag on top
  typedef struct packed {
    logic       frame_err;
    uart_byte_t data;
  } uart_rx_entry_t;

  // Wishbone word offsets
  typedef enum logic [1:0] {
    REG_DATA   = 2'd0,
    REG_STATUS = 2'd1,
    REG_CTRL   = 2'd2,
    REG_DIV    = 2'd3
  } uart_reg_addr_t;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;

endpackage

// ==== logic/uart_baud_timer.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_baud_timer (
  input  logic                       rxclk,
  input  logic                       reset,
  input  logic [`UART_DIV_WIDTH-1:0] divisor,
  output logic                       tick
);

  logic [`UART_DIV_WIDTH-1:0] count;

  // Down-counter, period is divisor+1 clocks
  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (count == '0) begin
      count <= divisor;  // New divisor only seen here
    end else begin
      count <= count - 1'b1;
    end
  end

  // Oversample strobe shared by rx and tx
  assign tick = (count == '0);

endmodule

// ==== logic/uart_rx_fsm.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_fsm (
  input  logic                     rxclk,
  input  logic                     reset,
  input  logic                     tick,
  input  logic                     rx_enable,
  input  logic                     rx_in,
  output logic                     push,
  output uart_pkg::uart_rx_entry_t entry
);
  import uart_pkg::*;

  localparam int IDX_W = $clog2(`UART_DATA_BITS);

  logic [1:0]       sync;
  logic             rx_s;
  uart_rx_state_t   state;
  logic [3:0]       os_cnt;
  logic [IDX_W-1:0] bit_idx;
  uart_byte_t       shift_reg;
  logic             half_bit;
  logic             full_bit;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rx_in};
    end
  end

  assign rx_s     = sync[1];
  assign half_bit = tick && (os_cnt == 4'd7);
  assign full_bit = tick && (os_cnt == 4'd15);

  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      state   <= RX_IDLE;
      os_cnt  <= '0;
      bit_idx <= '0;
      push    <= 1'b0;
    end else begin
      push <= 1'b0;
      if (!rx_enable) begin
        state <= RX_IDLE;  // Abort at once
      end else begin
        if (tick) os_cnt <= os_cnt + 1'b1;
        case (state)
          RX_IDLE: if (tick && !rx_s) begin
            state  <= RX_START;
            os_cnt <= '0;
          end
          RX_START: if (half_bit) begin
            // Middle of start bit, high means glitch
            state   <= rx_s ? RX_IDLE : RX_DATA;
            os_cnt  <= '0;
            bit_idx <= '0;
          end
          RX_DATA: if (full_bit) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) state <= RX_STOP;
          end
          RX_STOP: if (full_bit) begin
            state <= RX_IDLE;
            push  <= 1'b1;
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  // Data assembly, LSB arrives first
  always_ff @(posedge rxclk) begin
    if (state == RX_DATA && full_bit) begin
      shift_reg <= {rx_s, shift_reg[`UART_DATA_BITS-1:1]};
    end
    if (state == RX_STOP && full_bit) begin
      entry.data      <= shift_reg;
      entry.frame_err <= ~rx_s;  // Low stop bit
    end
  end

endmodule

// ==== logic/uart_tx_fsm.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_fsm (
  input  logic                 rxclk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 tx_enable,
  input  logic                 fifo_empty,
  input  uart_pkg::uart_byte_t fifo_data,
  output logic                 pop,
  output logic                 tx_out,
  output logic                 busy
);
  import uart_pkg::*;

  localparam int IDX_W = $clog2(`UART_DATA_BITS);

  uart_tx_state_t   state;
  logic [3:0]       os_cnt;
  logic [IDX_W-1:0] bit_idx;
  uart_byte_t       shift_reg;
  logic             bit_end;

  assign bit_end = tick && (os_cnt == 4'd15);

  // Take a byte from idle or straight after a stop bit
  assign pop = tick && tx_enable && !fifo_empty &&
               ((state == TX_IDLE) || (state == TX_STOP && os_cnt == 4'd15));

  assign busy = (state != TX_IDLE) || pop;

  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      state   <= TX_IDLE;
      os_cnt  <= '0;
      bit_idx <= '0;
      tx_out  <= 1'b1;
    end else if (pop) begin
      state  <= TX_START;
      os_cnt <= '0;
      tx_out <= 1'b0;  // Start bit
    end else if (tick && state != TX_IDLE) begin
      os_cnt <= os_cnt + 1'b1;
      if (os_cnt == 4'd15) begin
        case (state)
          TX_START: begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx_out  <= shift_reg[0];
          end
          TX_DATA: begin
            if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) begin
              state  <= TX_STOP;
              tx_out <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_out  <= shift_reg[0];
            end
          end
          default: state <= TX_IDLE;  // End of stop bit
        endcase
      end
    end
  end

  // Shifter feeds tx_out from bit 0
  always_ff @(posedge rxclk) begin
    if (pop) begin
      shift_reg <= fifo_data;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_fifo #(
  parameter type payload_t = uart_pkg::uart_byte_t
) (
  input  logic     rxclk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     full,
  output logic     empty
);

  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;   // Overflow ignored
  assign do_pop   = pop && !empty;   // Underflow ignored
  assign pop_data = mem[rd_ptr];     // Head always visible

  always_ff @(posedge rxclk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/uart_wb_regs.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_wb_regs (
  input  logic                       rxclk,
  input  logic                       reset,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [1:0]                 wb_adr,
  input  logic [31:0]                wb_dat_i,
  output logic [31:0]                wb_dat_o,
  output logic                       wb_ack,
  output logic                       tx_push,
  output uart_pkg::uart_byte_t       tx_push_data,
  input  logic                       tx_full,
  output logic                       rx_pop,
  input  uart_pkg::uart_rx_entry_t   rx_pop_data,
  input  logic                       rx_empty,
  input  logic                       rx_push,
  input  logic                       rx_full,
  input  logic                       tx_empty,
  input  logic                       tx_busy,
  output logic                       rx_enable,
  output logic                       tx_enable,
  output logic [`UART_DIV_WIDTH-1:0] divisor
);
  import uart_pkg::*;

  localparam int ENTRY_W = $bits(uart_rx_entry_t);

  uart_reg_addr_t reg_addr;
  logic           acc;
  logic           wr;
  logic           rd;
  logic           overrun;

  assign reg_addr = uart_reg_addr_t'(wb_adr);

  // One-cycle ack, so a held strobe acks every other cycle
  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end
  end

  assign acc = wb_ack && wb_cyc && wb_stb;  // Access lands on the ack cycle
  assign wr  = acc && wb_we;
  assign rd  = acc && !wb_we;

  // FIFO strobes, full and empty handled inside the FIFOs
  assign tx_push      = wr && (reg_addr == REG_DATA);
  assign tx_push_data = wb_dat_i[`UART_DATA_BITS-1:0];
  assign rx_pop       = rd && (reg_addr == REG_DATA);

  always_ff @(posedge rxclk or posedge reset) begin
    if (reset) begin
      rx_enable <= 1'b0;
      tx_enable <= 1'b0;
      divisor   <= `UART_DEFAULT_DIV;
      overrun   <= 1'b0;
    end else begin
      if (wr && reg_addr == REG_CTRL) begin
        rx_enable <= wb_dat_i[0];
        tx_enable <= wb_dat_i[1];
      end
      if (wr && reg_addr == REG_DIV) divisor <= wb_dat_i[`UART_DIV_WIDTH-1:0];
      // Set wins over the clear-on-read
      if (rx_push && rx_full) begin
        overrun <= 1'b1;
      end else if (rd && reg_addr == REG_STATUS) begin
        overrun <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    wb_dat_o = '0;
    case (reg_addr)
      REG_DATA: begin
        if (!rx_empty) wb_dat_o[ENTRY_W-1:0] = rx_pop_data;
      end
      REG_STATUS: wb_dat_o[3:0] = {overrun, tx_empty & ~tx_busy, tx_full, ~rx_empty};
      REG_CTRL:   wb_dat_o[1:0] = {tx_enable, rx_enable};
      REG_DIV:    wb_dat_o[`UART_DIV_WIDTH-1:0] = divisor;
      default:    wb_dat_o = '0;
    endcase
  end

endmodule

// ==== logic/uart_core.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_core (
  input  logic        rxclk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack,
  input  logic        rx_in,
  output logic        tx_out
);
  import uart_pkg::*;

  logic                       tick;
  logic                       rx_enable;
  logic                       tx_enable;
  logic [`UART_DIV_WIDTH-1:0] divisor;
  logic                       tx_push;
  uart_byte_t                 tx_push_data;
  logic                       tx_pop;
  uart_byte_t                 tx_pop_data;
  logic                       tx_full;
  logic                       tx_empty;
  logic                       tx_busy;
  logic                       rx_push;
  uart_rx_entry_t             rx_push_data;
  logic                       rx_pop;
  uart_rx_entry_t             rx_pop_data;
  logic                       rx_full;
  logic                       rx_empty;

  uart_baud_timer i_baud_timer (
    .rxclk   (rxclk),
    .reset   (reset),
    .divisor (divisor),
    .tick    (tick)
  );

  uart_rx_fsm i_rx_fsm (
    .rxclk     (rxclk),
    .reset     (reset),
    .tick      (tick),
    .rx_enable (rx_enable),
    .rx_in     (rx_in),
    .push      (rx_push),
    .entry     (rx_push_data)
  );

  uart_tx_fsm i_tx_fsm (
    .rxclk      (rxclk),
    .reset      (reset),
    .tick       (tick),
    .tx_enable  (tx_enable),
    .fifo_empty (tx_empty),
    .fifo_data  (tx_pop_data),
    .pop        (tx_pop),
    .tx_out     (tx_out),
    .busy       (tx_busy)
  );

  uart_fifo #(.payload_t(uart_byte_t)) tx_fifo (
    .rxclk     (rxclk),
    .reset     (reset),
    .push      (tx_push),
    .push_data (tx_push_data),
    .pop       (tx_pop),
    .pop_data  (tx_pop_data),
    .full      (tx_full),
    .empty     (tx_empty)
  );

  uart_fifo #(.payload_t(uart_rx_entry_t)) rx_fifo (
    .rxclk     (rxclk),
    .reset     (reset),
    .push      (rx_push),
    .push_data (rx_push_data),
    .pop       (rx_pop),
    .pop_data  (rx_pop_data),
    .full      (rx_full),
    .empty     (rx_empty)
  );

  uart_wb_regs i_wb_regs (
    .rxclk        (rxclk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .tx_push      (tx_push),
    .tx_push_data (tx_push_data),
    .tx_full      (tx_full),
    .rx_pop       (rx_pop),
    .rx_pop_data  (rx_pop_data),
    .rx_empty     (rx_empty),
    .rx_push      (rx_push),
    .rx_full      (rx_full),
    .tx_empty     (tx_empty),
    .tx_busy      (tx_busy),
    .rx_enable    (rx_enable),
    .tx_enable    (tx_enable),
    .divisor      (divisor)
  );

endmodule

// ==== test/tb_uart_core.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_uart_core;
  import uart_pkg::*;

  localparam int DEPTH = `UART_FIFO_DEPTH;

  logic        rxclk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack;
  logic        rx_in;
  logic        tx_out;

  logic        loop_en;   // rx_in follows tx_out
  logic        line_drv;  // Serial line driven by send_frame
  int          bit_clks;
  int          err_cnt;
  int          timeout_cnt;
  logic [31:0] lcg_state;

  uart_core i_uart_core (
    .rxclk    (rxclk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .rx_in    (rx_in),
    .tx_out   (tx_out)
  );

  always #2 rxclk = ~rxclk;

  assign rx_in = loop_en ? tx_out : line_drv;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_byte(output uart_byte_t b);
    lcg_state = lcg_step(lcg_state);
    b = lcg_state[23:16];  // Upper bits are less regular
  endtask

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_entry(input string name, input uart_rx_entry_t exp,
                             input uart_rx_entry_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    uart_rx_state_t rs;
    uart_tx_state_t ts;
    rs = i_uart_core.i_rx_fsm.state;
    ts = i_uart_core.i_tx_fsm.state;
    $display("Timeout while waiting for %s (rx FSM in %s, tx FSM in %s)",
             what, rs.name(), ts.name());
    timeout_cnt++;
  endtask

  // All tasks start and end 1 ns after a rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge rxclk);
    #1;
  endtask

  task automatic wb_transfer(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    n = 0;
    wait_clks(1);
    while (!wb_ack && n < 16) begin
      wait_clks(1);
      n++;
    end
    if (!wb_ack) report_timeout("wb_ack");
    rdata = wb_dat_o;  // Read data valid on the ack cycle
    wait_clks(1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input uart_reg_addr_t adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_transfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input uart_reg_addr_t adr, output logic [31:0] data);
    wb_transfer(1'b0, adr, 32'h0, data);
  endtask

  task automatic wait_status_bit(input int idx, input string what);
    logic [31:0] st;
    int n;
    n = 0;
    st = '0;
    while (!st[idx] && n < 2000) begin
      wb_read(REG_STATUS, st);
      n++;
    end
    if (!st[idx]) report_timeout(what);
  endtask

  task automatic set_divisor(input logic [15:0] d);
    wb_write(REG_DIV, {16'h0, d});
    wait_clks(bit_clks / 16);  // Old count wraps within one old tick period
    bit_clks = 16 * (int'(d) + 1);
  endtask

  // Frame on the task-driven line with the stop bit value from the caller
  task automatic send_frame(input uart_byte_t b, input logic stop);
    uart_byte_t d;
    d = b;
    line_drv = 1'b0;
    wait_clks(bit_clks);
    repeat (`UART_DATA_BITS) begin
      line_drv = d[0];
      d = d >> 1;
      wait_clks(bit_clks);
    end
    line_drv = stop;
    wait_clks(bit_clks);
    line_drv = 1'b1;
    wait_clks(bit_clks);  // Idle gap
  endtask

  task automatic test_reset_values();
    logic [31:0] rd;
    wb_read(REG_STATUS, rd);
    check_word("STATUS after reset", 32'h4, rd);
    wb_read(REG_CTRL, rd);
    check_word("CTRL after reset", 32'h0, rd);
    wb_read(REG_DIV, rd);
    check_word("DIV after reset", {16'h0, `UART_DEFAULT_DIV}, rd);
    check_word("tx_out after reset", 32'h1, {31'h0, tx_out});
  endtask

  task automatic test_loopback();
    uart_byte_t  sent[$];
    uart_byte_t  b;
    logic [31:0] rd;
    set_divisor(16'd1);
    loop_en = 1'b1;
    wb_write(REG_CTRL, 32'h3);
    repeat (6) begin
      next_byte(b);
      sent.push_back(b);
      wb_write(REG_DATA, {24'h0, b});
    end
    repeat (6) begin
      wait_status_bit(0, "loopback receive data");
      wb_read(REG_DATA, rd);
      b = sent.pop_front();
      check_entry("DATA loopback", uart_rx_entry_t'({1'b0, b}), rd[8:0]);
    end
  endtask

  task automatic test_line_format();
    uart_byte_t  b;
    uart_byte_t  got;
    logic [31:0] rd;
    int          n;
    wb_write(REG_CTRL, 32'h2);  // tx only
    next_byte(b);
    wb_write(REG_DATA, {24'h0, b});
    n = 0;
    while (tx_out && n < 4 * bit_clks) begin
      wait_clks(1);
      n++;
    end
    if (tx_out) begin
      report_timeout("start bit on tx_out");
    end else begin
      wait_clks(bit_clks / 2);  // Middle of start bit
      check_word("tx_out start bit", 32'h0, {31'h0, tx_out});
      got = '0;
      repeat (`UART_DATA_BITS) begin
        wait_clks(bit_clks);
        got = {tx_out, got[`UART_DATA_BITS-1:1]};  // LSB first
      end
      check_byte("tx_out data bits", b, got);
      wait_clks(bit_clks);
      check_word("tx_out stop bit", 32'h1, {31'h0, tx_out});
    end
    wait_status_bit(2, "transmit idle");
    wb_read(REG_STATUS, rd);
    check_word("STATUS after frame", 32'h4, rd);
  endtask

  task automatic test_framing_error();
    uart_byte_t  b1;
    uart_byte_t  b2;
    logic [31:0] rd;
    loop_en  = 1'b0;
    line_drv = 1'b1;
    wb_write(REG_CTRL, 32'h1);  // rx only
    next_byte(b1);
    next_byte(b2);
    send_frame(b1, 1'b0);
    send_frame(b2, 1'b1);
    wait_status_bit(0, "bad-stop frame");
    wb_read(REG_DATA, rd);
    check_entry("DATA bad stop", uart_rx_entry_t'({1'b1, b1}), rd[8:0]);
    wait_status_bit(0, "good frame");
    wb_read(REG_DATA, rd);
    check_entry("DATA good stop", uart_rx_entry_t'({1'b0, b2}), rd[8:0]);
  endtask

  task automatic test_rx_overrun();
    uart_byte_t  sent[$];
    uart_byte_t  b;
    logic [31:0] rd;
    repeat (DEPTH + 2) begin
      next_byte(b);
      sent.push_back(b);
      send_frame(b, 1'b1);
    end
    // Reading STATUS clears overrun
    wb_read(REG_STATUS, rd);
    check_word("STATUS overrun set", 32'hd, rd);
    wb_read(REG_STATUS, rd);
    check_word("STATUS overrun cleared", 32'h5, rd);
    repeat (DEPTH) begin
      wb_read(REG_DATA, rd);
      b = sent.pop_front();
      check_entry("DATA after overrun", uart_rx_entry_t'({1'b0, b}), rd[8:0]);
    end
    wb_read(REG_STATUS, rd);
    check_word("STATUS rx drained", 32'h4, rd);
  endtask

  task automatic test_tx_backpressure();
    uart_byte_t  sent[$];
    uart_byte_t  b;
    logic [31:0] rd;
    wb_write(REG_CTRL, 32'h0);
    loop_en = 1'b1;
    repeat (DEPTH + 3) begin
      next_byte(b);
      sent.push_back(b);
      wb_write(REG_DATA, {24'h0, b});
    end
    wb_read(REG_STATUS, rd);
    check_word("STATUS tx full", 32'h2, rd);
    wb_write(REG_CTRL, 32'h3);
    repeat (DEPTH) begin
      wait_status_bit(0, "back-pressure receive data");
      wb_read(REG_DATA, rd);
      b = sent.pop_front();
      check_entry("DATA back-pressure", uart_rx_entry_t'({1'b0, b}), rd[8:0]);
    end
    wait_status_bit(2, "transmit idle after drain");
    wb_read(REG_STATUS, rd);
    check_word("STATUS no extra bytes", 32'h4, rd);  // Dropped writes never sent
  endtask

  initial begin
    rxclk       = 1'b0;
    reset       = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 2'd0;
    wb_dat_i    = 32'h0;
    loop_en     = 1'b0;
    line_drv    = 1'b1;
    bit_clks    = 16 * (`UART_DEFAULT_DIV + 1);
    err_cnt     = 0;
    timeout_cnt = 0;
    lcg_state   = 32'h9a7a;
    repeat (10) @(posedge rxclk);
    #1;
    reset = 1'b0;
    wait_clks(2);

    test_reset_values();
    test_loopback();
    test_line_format();
    test_framing_error();
    test_rx_overrun();
    test_tx_backpressure();

    $display("Run complete with %0d value errors and %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
logic/uart_pkg.sv
logic/uart_baud_timer.sv
logic/uart_rx_fsm.sv
logic/uart_tx_fsm.sv
logic/uart_fifo.sv
logic/uart_wb_regs.sv
logic/uart_core.sv
test/tb_uart_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_uart_core
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
